// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// --------------------
// Datapath widths
// --------------------
`define XLEN       64 // Data word width.
`define ALU_CTRL_W 5  // ALU control code width.

// --------------------
// RISC-V major opcodes
// --------------------
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011
`define OPC_SYSTEM    7'b1110011

`endif

// File: logic/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;     // One data word.
    typedef logic [`ALU_CTRL_W-1:0] alu_ctrl_t; // ALU control code.
    typedef logic [6:0]             opcode_t;   // Major opcode field.

    // ALU operation class from the instruction decoder.
    typedef enum logic [2:0] {
        ALU_OP_ADDR   = 3'b000, // Loads and stores.
        ALU_OP_BRANCH = 3'b001,
        ALU_OP_INT    = 3'b010,
        ALU_OP_WORD   = 3'b011,
        ALU_OP_CSR    = 3'b100,
        ALU_OP_NONE   = 3'b111  // Unknown opcode.
    } alu_op_e;

    // --------------------
    // ALU control codes
    // --------------------
    localparam alu_ctrl_t ALU_ADD   = 5'd0;
    localparam alu_ctrl_t ALU_SUB   = 5'd1;
    localparam alu_ctrl_t ALU_AND   = 5'd2;
    localparam alu_ctrl_t ALU_OR    = 5'd3;
    localparam alu_ctrl_t ALU_XOR   = 5'd4;
    localparam alu_ctrl_t ALU_SLL   = 5'd5;
    localparam alu_ctrl_t ALU_SLT   = 5'd6;
    localparam alu_ctrl_t ALU_SLTU  = 5'd7;
    localparam alu_ctrl_t ALU_SRL   = 5'd8;
    localparam alu_ctrl_t ALU_SRA   = 5'd9;
    localparam alu_ctrl_t ALU_ADDW  = 5'd10;
    localparam alu_ctrl_t ALU_SUBW  = 5'd11;
    localparam alu_ctrl_t ALU_SLLW  = 5'd12;
    localparam alu_ctrl_t ALU_SRLW  = 5'd13;
    localparam alu_ctrl_t ALU_SRAW  = 5'd14;
    localparam alu_ctrl_t ALU_ADDIW = 5'd15;
    localparam alu_ctrl_t ALU_CSRRW = 5'd16;
    localparam alu_ctrl_t ALU_CSRRS = 5'd17;
    localparam alu_ctrl_t ALU_CSRRC = 5'd18;
    localparam alu_ctrl_t ALU_DIVW  = 5'd19;
    localparam alu_ctrl_t ALU_MULW  = 5'd20;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

`include "core_config.svh"

module instr_decoder
(
    input  logic [31:0]       i_instr,
    output core_pkg::alu_op_e o_alu_op,
    output logic              o_src_b_imm,
    output logic              o_src_csr_rs1,
    output logic              o_src_a_csr,
    output core_pkg::xlen_t   o_imm
);

    import core_pkg::*;

    opcode_t    s_opcode;
    logic [2:0] s_func_3;
    xlen_t      s_imm_i;
    xlen_t      s_imm_s;
    xlen_t      s_imm_b;
    xlen_t      s_imm_csr;

    assign s_opcode = i_instr[6:0];
    assign s_func_3 = i_instr[14:12];

    // --------------------
    // Immediate generation
    // --------------------
    assign s_imm_i = { {(`XLEN-12){i_instr[31]}}, i_instr[31:20] };

    assign s_imm_s = { {(`XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7] };

    // Branch offset, always even.
    assign s_imm_b = { {(`XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                       i_instr[30:25], i_instr[11:8], 1'b0 };

    // The rs1 field read as an unsigned 5-bit value.
    assign s_imm_csr = { {(`XLEN-5){1'b0}}, i_instr[19:15] };

    // --------------------
    // Opcode decode
    // --------------------
    always_comb begin
        o_alu_op      = ALU_OP_NONE;
        o_src_b_imm   = 1'b0;
        o_src_csr_rs1 = 1'b0;
        o_src_a_csr   = 1'b0;
        o_imm         = s_imm_i;

        case (s_opcode)
            `OPC_LOAD: begin
                o_alu_op    = ALU_OP_ADDR; // Address is rs1 plus offset.
                o_src_b_imm = 1'b1;
            end
            `OPC_STORE: begin
                o_alu_op    = ALU_OP_ADDR;
                o_src_b_imm = 1'b1;
                o_imm       = s_imm_s;     // Split store offset.
            end
            `OPC_BRANCH: begin
                o_alu_op = ALU_OP_BRANCH;  // Compare by subtraction.
                o_imm    = s_imm_b;
            end
            `OPC_OP_IMM: begin
                o_alu_op    = ALU_OP_INT;
                o_src_b_imm = 1'b1;
            end
            `OPC_OP: begin
                o_alu_op = ALU_OP_INT;
            end
            `OPC_OP_IMM_32: begin
                o_alu_op    = ALU_OP_WORD;
                o_src_b_imm = 1'b1;
            end
            `OPC_OP_32: begin
                o_alu_op = ALU_OP_WORD;
            end
            `OPC_SYSTEM: begin
                o_alu_op      = ALU_OP_CSR;
                o_src_a_csr   = 1'b1;         // Old CSR value on A.
                o_src_b_imm   = s_func_3[2];  // CSRR*I forms.
                o_src_csr_rs1 = ~s_func_3[2]; // Register forms take rs1.
                o_imm         = s_imm_csr;
            end
            default: begin
                o_alu_op = ALU_OP_NONE; // Flagged later by the ALU decoder.
            end
        endcase
    end

endmodule

// File: logic/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder
(
    input  logic [2:0]          i_alu_op,
    input  logic [2:0]          i_func_3,
    input  logic                i_func_7_5,
    input  logic                i_func_7_0,
    input  logic                i_op_5,
    output core_pkg::alu_ctrl_t o_alu_control,
    output logic                o_illegal_instr
);

    import core_pkg::*;

    logic [1:0] s_op_func_7;

    // Opcode bit 5 separates register forms from immediate forms.
    assign s_op_func_7 = { i_op_5, i_func_7_5 };

    always_comb begin
        o_alu_control   = ALU_ADD;
        o_illegal_instr = 1'b0;

        case (alu_op_e'(i_alu_op))
            ALU_OP_ADDR:   o_alu_control = ALU_ADD; // Load and store address.
            ALU_OP_BRANCH: o_alu_control = ALU_SUB; // Zero flag drives branch.

            // --------------------
            // OP and OP-IMM
            // --------------------
            ALU_OP_INT: begin
                case (i_func_3)
                    3'b000: begin
                        if (s_op_func_7 == 2'b11) begin
                            o_alu_control = ALU_SUB;
                        end else begin
                            o_alu_control = ALU_ADD; // ADD and ADDI.
                        end
                    end
                    3'b001: o_alu_control = ALU_SLL;
                    3'b010: o_alu_control = ALU_SLT;
                    3'b011: o_alu_control = ALU_SLTU;
                    3'b100: o_alu_control = ALU_XOR;
                    3'b101: begin
                        if (i_func_7_5) begin
                            o_alu_control = ALU_SRA;
                        end else begin
                            o_alu_control = ALU_SRL;
                        end
                    end
                    3'b110: o_alu_control = ALU_OR;
                    default: o_alu_control = ALU_AND;
                endcase
            end

            // --------------------
            // OP-32 and OP-IMM-32
            // --------------------
            ALU_OP_WORD: begin
                case (i_func_3)
                    3'b000: begin
                        if (i_func_7_0) begin
                            // Bit 0 of funct7 marks the M extension.
                            if (i_op_5) begin
                                o_alu_control = ALU_MULW;
                            end else begin
                                o_alu_control = ALU_ADDIW;
                            end
                        end else begin
                            case (s_op_func_7)
                                2'b11:   o_alu_control = ALU_SUBW;
                                2'b10:   o_alu_control = ALU_ADDW;
                                default: o_alu_control = ALU_ADDIW;
                            endcase
                        end
                    end
                    3'b001: o_alu_control = ALU_SLLW;
                    3'b100: o_alu_control = ALU_DIVW; // Also hit by OP-IMM-32.
                    3'b101: begin
                        if (i_func_7_5) begin
                            o_alu_control = ALU_SRAW;
                        end else begin
                            o_alu_control = ALU_SRLW;
                        end
                    end
                    default: begin
                        o_alu_control   = ALU_ADD;
                        o_illegal_instr = 1'b1;
                    end
                endcase
            end

            // CSR read-modify-write, funct3 bit 2 picks the operand only.
            ALU_OP_CSR: begin
                case (i_func_3[1:0])
                    2'b01: o_alu_control = ALU_CSRRW;
                    2'b10: o_alu_control = ALU_CSRRS;
                    2'b11: o_alu_control = ALU_CSRRC;
                    default: begin
                        o_alu_control   = ALU_ADD;
                        o_illegal_instr = 1'b1; // ECALL and friends.
                    end
                endcase
            end

            default: begin
                o_alu_control   = ALU_ADD;
                o_illegal_instr = 1'b1;
            end
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

`include "core_config.svh"

module alu
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  core_pkg::alu_ctrl_t i_alu_control,
    input  logic                i_illegal,
    input  core_pkg::xlen_t     i_src_a,
    input  core_pkg::xlen_t     i_src_b,
    output logic                o_valid,
    output core_pkg::xlen_t     o_result,
    output logic                o_zero,
    output logic                o_illegal
);

    import core_pkg::*;

    logic [5:0]         s_shamt;
    logic [4:0]         s_shamt_w;
    logic [31:0]        s_a_w;
    logic [31:0]        s_b_w;
    logic [31:0]        s_mul_w;
    logic signed [31:0] s_div_w;
    logic [31:0]        s_word;
    xlen_t              s_result;
    logic               s_zero;

    assign s_shamt   = i_src_b[5:0];
    assign s_shamt_w = i_src_b[4:0];
    assign s_a_w     = i_src_a[31:0];
    assign s_b_w     = i_src_b[31:0];

    // Low half of the product is the same for signed and unsigned.
    assign s_mul_w = s_a_w * s_b_w;

    // --------------------
    // Signed word divide
    // --------------------
    always_comb begin
        if (s_b_w == 32'd0) begin
            s_div_w = -32'sd1; // Divide by zero gives all ones.
        end else if ((s_a_w == 32'h8000_0000) && (s_b_w == 32'hffff_ffff)) begin
            s_div_w = 32'sh8000_0000; // Overflow keeps the dividend.
        end else begin
            s_div_w = $signed(s_a_w) / $signed(s_b_w);
        end
    end

    // --------------------
    // 32-bit word results
    // --------------------
    always_comb begin
        case (i_alu_control)
            ALU_ADDW,
            ALU_ADDIW: s_word = s_a_w + s_b_w;
            ALU_SUBW:  s_word = s_a_w - s_b_w;
            ALU_SLLW:  s_word = s_a_w << s_shamt_w;
            ALU_SRLW:  s_word = s_a_w >> s_shamt_w;
            ALU_SRAW:  s_word = $signed(s_a_w) >>> s_shamt_w;
            ALU_MULW:  s_word = s_mul_w;
            ALU_DIVW:  s_word = s_div_w;
            default:   s_word = 32'd0;
        endcase
    end

    // --------------------
    // Full-width result
    // --------------------
    always_comb begin
        case (i_alu_control)
            ALU_ADD:  s_result = i_src_a + i_src_b;
            ALU_SUB:  s_result = i_src_a - i_src_b;
            ALU_AND:  s_result = i_src_a & i_src_b;
            ALU_OR:   s_result = i_src_a | i_src_b;
            ALU_XOR:  s_result = i_src_a ^ i_src_b;
            ALU_SLL:  s_result = i_src_a << s_shamt;
            ALU_SLT:  s_result = { {(`XLEN-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b) };
            ALU_SLTU: s_result = { {(`XLEN-1){1'b0}}, i_src_a < i_src_b };
            ALU_SRL:  s_result = i_src_a >> s_shamt;
            ALU_SRA:  s_result = $signed(i_src_a) >>> s_shamt;

            ALU_ADDW, ALU_ADDIW, ALU_SUBW, ALU_SLLW,
            ALU_SRLW, ALU_SRAW,  ALU_MULW, ALU_DIVW: begin
                s_result = { {(`XLEN-32){s_word[31]}}, s_word }; // Sign-extend word.
            end

            // New CSR value, A holds the old one.
            ALU_CSRRW: s_result = i_src_b;
            ALU_CSRRS: s_result = i_src_a | i_src_b;
            ALU_CSRRC: s_result = i_src_a & ~i_src_b;

            default:   s_result = '0;
        endcase
    end

    assign s_zero = (s_result == '0);

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid   <= 1'b0;
            o_zero    <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_valid <= i_valid; // One strobe in, one strobe out.
            if (i_valid) begin
                o_zero    <= s_zero;
                o_illegal <= i_illegal;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_result <= s_result; // Holds between strobes.
        end
    end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic [31:0]     i_instr,
    input  core_pkg::xlen_t i_rs1_data,
    input  core_pkg::xlen_t i_rs2_data,
    input  core_pkg::xlen_t i_csr_data,
    output logic            o_valid,
    output core_pkg::xlen_t o_result,
    output logic            o_zero,
    output logic            o_illegal
);

    import core_pkg::*;

    alu_op_e   s_alu_op;
    logic      s_src_b_imm;
    logic      s_src_csr_rs1;
    logic      s_src_a_csr;
    xlen_t     s_imm;
    xlen_t     s_src_a;
    xlen_t     s_src_b;
    alu_ctrl_t s_alu_control;
    logic      s_illegal;

    instr_decoder u_instr_decoder (
        .i_instr       (i_instr),
        .o_alu_op      (s_alu_op),
        .o_src_b_imm   (s_src_b_imm),
        .o_src_csr_rs1 (s_src_csr_rs1),
        .o_src_a_csr   (s_src_a_csr),
        .o_imm         (s_imm)
    );

    alu_decoder u_alu_decoder (
        .i_alu_op        (s_alu_op),
        .i_func_3        (i_instr[14:12]),
        .i_func_7_5      (i_instr[30]),
        .i_func_7_0      (i_instr[25]),
        .i_op_5          (i_instr[5]),
        .o_alu_control   (s_alu_control),
        .o_illegal_instr (s_illegal)
    );

    // --------------------
    // Operand selection
    // --------------------
    assign s_src_a = s_src_a_csr ? i_csr_data : i_rs1_data;

    always_comb begin
        if (s_src_csr_rs1) begin
            s_src_b = i_rs1_data; // CSR register forms write from rs1.
        end else if (s_src_b_imm) begin
            s_src_b = s_imm;
        end else begin
            s_src_b = i_rs2_data;
        end
    end

    alu u_alu (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_alu_control (s_alu_control),
        .i_illegal     (s_illegal),
        .i_src_a       (s_src_a),
        .i_src_b       (s_src_b),
        .o_valid       (o_valid),
        .o_result      (o_result),
        .o_zero        (o_zero),
        .o_illegal     (o_illegal)
    );

endmodule

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Operations known to the expected-result model.
typedef enum int {
    M_ADD, M_SUB, M_AND, M_OR, M_XOR, M_SLL, M_SRL, M_SRA, M_SLT, M_SLTU,
    M_ADDW, M_SUBW, M_SLLW, M_SRLW, M_SRAW, M_MULW, M_DIVW,
    M_CSRRW, M_CSRRS, M_CSRRC
} model_op_e;

// --------------------
// Instruction encoders
// --------------------
function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic [6:0] opcode);
    return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode}; // Fixed rs2, rs1 and rd.
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] funct3, input logic [6:0] opcode);
    return {imm, rs1, funct3, 5'd3, opcode};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] funct3);
    return {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], `OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] funct3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], `OPC_BRANCH};
endfunction

function automatic xlen_t sext12(input logic [11:0] imm);
    return {{(`XLEN-12){imm[11]}}, imm};
endfunction

function automatic xlen_t sext32(input logic [31:0] word);
    return {{(`XLEN-32){word[31]}}, word};
endfunction

// --------------------
// Expected results
// --------------------
function automatic xlen_t model_result(input model_op_e op, input xlen_t a, input xlen_t b);
    logic [31:0] aw;
    logic [31:0] bw;
    logic [31:0] rw;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    xlen_t       res;
    aw    = a[31:0];
    bw    = b[31:0];
    rw    = 32'd0;
    res   = '0;
    mag_a = aw[31] ? -aw : aw; // Magnitudes for the signed divide.
    mag_b = bw[31] ? -bw : bw;
    case (op)
        M_ADD:   res = a + b;
        M_SUB:   res = a - b;
        M_AND:   res = a & b;
        M_OR:    res = a | b;
        M_XOR:   res = a ^ b;
        M_SLL:   res = a << b[5:0];
        M_SRL:   res = a >> b[5:0];
        M_SRA:   res = $signed(a) >>> b[5:0];
        M_SLT:   res = ($signed(a) < $signed(b)) ? xlen_t'(1) : '0;
        M_SLTU:  res = (a < b) ? xlen_t'(1) : '0;
        M_ADDW:  rw = aw + bw;
        M_SUBW:  rw = aw - bw;
        M_SLLW:  rw = aw << bw[4:0];
        M_SRLW:  rw = aw >> bw[4:0];
        M_SRAW:  rw = $signed(aw) >>> bw[4:0];
        M_MULW:  rw = aw * bw;
        M_DIVW: begin
            if (bw == 32'd0) begin
                rw = '1; // Divide by zero.
            end else begin
                rw = mag_a / mag_b;  // Overflow case falls out as 2**31.
                if (aw[31] ^ bw[31]) begin
                    rw = -rw;
                end
            end
        end
        M_CSRRW: res = b;
        M_CSRRS: res = a | b;
        M_CSRRC: res = a & ~b;
        default: res = '0;
    endcase
    if (op inside {M_ADDW, M_SUBW, M_SLLW, M_SRLW, M_SRAW, M_MULW, M_DIVW}) begin
        res = sext32(rw);
    end
    return res;
endfunction

`endif

// File: testbench/tb_exec_unit.sv
`timescale 1ns/1ps

`include "core_config.svh"

module tb_exec_unit;

    import core_pkg::*;

    `include "tb_ref_model.svh"

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 48;
    localparam int WATCHDOG_NS = NUM_TESTS * 20 * CLK_PERIOD;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic [31:0] i_instr;
    xlen_t       i_rs1_data;
    xlen_t       i_rs2_data;
    xlen_t       i_csr_data;
    logic        o_valid;
    xlen_t       o_result;
    logic        o_zero;
    logic        o_illegal;
    int          error_count;

    exec_unit i_exec_unit (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .i_csr_data (i_csr_data),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_zero     (o_zero),
        .o_illegal  (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "Simulation timed out");
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    task automatic check_value(input string what, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s is 0x%h, expected 0x%h", $time, what, actual,
                     expected);
            $display("** FAIL **");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic compare_outputs(input xlen_t exp_result, input logic exp_illegal,
                                   input logic with_result);
        check_value("o_valid", xlen_t'(o_valid), xlen_t'(1));
        check_value("o_illegal", xlen_t'(o_illegal), xlen_t'(exp_illegal));
        if (with_result) begin
            check_value("o_result", o_result, exp_result);
            check_value("o_zero", xlen_t'(o_zero), xlen_t'(exp_result == '0));
        end
    endtask

    task automatic drive_instr(input logic [31:0] instr, input xlen_t rs1, input xlen_t rs2,
                               input xlen_t csr);
        i_valid    <= 1'b1;
        i_instr    <= instr;
        i_rs1_data <= rs1;
        i_rs2_data <= rs2;
        i_csr_data <= csr;
    endtask

    // Drives one strobe and samples the result at the falling edge after the next rise.
    task automatic issue_and_check(input logic [31:0] instr, input xlen_t rs1,
                                   input xlen_t rs2, input xlen_t csr, input xlen_t exp_result,
                                   input logic exp_illegal, input logic with_result);
        @(posedge i_clk);
        drive_instr(instr, rs1, rs2, csr);
        @(posedge i_clk);
        i_valid <= 1'b0;
        @(negedge i_clk);
        compare_outputs(exp_result, exp_illegal, with_result);
    endtask

    task automatic r_type_random(input logic [6:0] funct7, input logic [2:0] funct3,
                                 input logic [6:0] opcode, input model_op_e op);
        xlen_t a;
        xlen_t b;
        a = rand_word();
        b = rand_word();
        issue_and_check(enc_r(funct7, funct3, opcode), a, b, rand_word(),
                        model_result(op, a, b), 1'b0, 1'b1);
    endtask

    task automatic i_type_random(input logic [11:0] imm, input logic [2:0] funct3,
                                 input logic [6:0] opcode, input model_op_e op);
        xlen_t a;
        a = rand_word();
        issue_and_check(enc_i(imm, 5'd1, funct3, opcode), a, rand_word(), rand_word(),
                        model_result(op, a, sext12(imm)), 1'b0, 1'b1);
    endtask

    task automatic csr_random(input logic [2:0] funct3, input model_op_e op);
        logic [4:0] uimm;
        xlen_t      rs1;
        xlen_t      csr;
        xlen_t      b;
        uimm = 5'($urandom);
        rs1  = rand_word();
        csr  = rand_word();
        b    = funct3[2] ? {{(`XLEN-5){1'b0}}, uimm} : rs1; // Immediate or register form.
        issue_and_check(enc_i(12'h340, uimm, funct3, `OPC_SYSTEM), rs1, rand_word(), csr,
                        model_result(op, csr, b), 1'b0, 1'b1);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic integer_ops();
        logic [5:0] shamt;
        shamt = 6'($urandom);
        @(negedge i_clk);
        check_value("o_valid after reset", xlen_t'(o_valid), '0);
        r_type_random(7'h00, 3'b000, `OPC_OP, M_ADD);
        r_type_random(7'h20, 3'b000, `OPC_OP, M_SUB);
        r_type_random(7'h00, 3'b001, `OPC_OP, M_SLL);
        r_type_random(7'h00, 3'b010, `OPC_OP, M_SLT);
        r_type_random(7'h00, 3'b011, `OPC_OP, M_SLTU);
        r_type_random(7'h00, 3'b100, `OPC_OP, M_XOR);
        r_type_random(7'h00, 3'b101, `OPC_OP, M_SRL);
        r_type_random(7'h20, 3'b101, `OPC_OP, M_SRA);
        r_type_random(7'h00, 3'b110, `OPC_OP, M_OR);
        r_type_random(7'h00, 3'b111, `OPC_OP, M_AND);
        i_type_random(12'($urandom), 3'b000, `OPC_OP_IMM, M_ADD);
        i_type_random(12'($urandom), 3'b010, `OPC_OP_IMM, M_SLT);
        i_type_random(12'($urandom), 3'b011, `OPC_OP_IMM, M_SLTU);
        i_type_random(12'($urandom), 3'b100, `OPC_OP_IMM, M_XOR);
        i_type_random(12'($urandom), 3'b110, `OPC_OP_IMM, M_OR);
        i_type_random(12'($urandom), 3'b111, `OPC_OP_IMM, M_AND);
        i_type_random({6'b000000, shamt}, 3'b001, `OPC_OP_IMM, M_SLL);
        i_type_random({6'b000000, shamt}, 3'b101, `OPC_OP_IMM, M_SRL);
        i_type_random({6'b010000, shamt}, 3'b101, `OPC_OP_IMM, M_SRA);
    endtask

    task automatic word_ops();
        xlen_t a;
        a = rand_word();
        r_type_random(7'h00, 3'b000, `OPC_OP_32, M_ADDW);
        r_type_random(7'h20, 3'b000, `OPC_OP_32, M_SUBW);
        r_type_random(7'h00, 3'b001, `OPC_OP_32, M_SLLW);
        r_type_random(7'h00, 3'b101, `OPC_OP_32, M_SRLW);
        r_type_random(7'h20, 3'b101, `OPC_OP_32, M_SRAW);
        r_type_random(7'h01, 3'b000, `OPC_OP_32, M_MULW);
        r_type_random(7'h01, 3'b100, `OPC_OP_32, M_DIVW);
        i_type_random(12'($urandom), 3'b000, `OPC_OP_IMM_32, M_ADDW);
        i_type_random({7'b0100000, 5'($urandom)}, 3'b101, `OPC_OP_IMM_32, M_SRAW);
        // Divisor with a zero low word and junk above it.
        issue_and_check(enc_r(7'h01, 3'b100, `OPC_OP_32), a, {$urandom, 32'd0}, '0, '1,
                        1'b0, 1'b1);
        issue_and_check(enc_r(7'h01, 3'b100, `OPC_OP_32), {a[63:32], 32'h8000_0000},
                        {32'd0, 32'hffff_ffff}, '0, 64'hffff_ffff_8000_0000, 1'b0, 1'b1);
    endtask

    task automatic mem_and_branch();
        logic [11:0] imm;
        xlen_t       a;
        xlen_t       b;
        imm = 12'($urandom);
        a   = rand_word();
        b   = rand_word();
        issue_and_check(enc_i(imm, 5'd1, 3'b011, `OPC_LOAD), a, b, '0,
                        a + sext12(imm), 1'b0, 1'b1);
        issue_and_check(enc_s(imm, 3'b011), a, b, '0, a + sext12(imm), 1'b0, 1'b1);
        issue_and_check(enc_b(13'h1f4, 3'b000), a, b, '0, a - b, 1'b0, 1'b1);
        issue_and_check(enc_b(13'h1f4, 3'b000), a, a, '0, '0, 1'b0, 1'b1); // Equal operands.
    endtask

    task automatic csr_ops();
        csr_random(3'b001, M_CSRRW);
        csr_random(3'b010, M_CSRRS);
        csr_random(3'b011, M_CSRRC);
        csr_random(3'b101, M_CSRRW);
        csr_random(3'b110, M_CSRRS);
        csr_random(3'b111, M_CSRRC);
    endtask

    task automatic illegal_instrs();
        // Any word with the LUI opcode.
        issue_and_check(enc_i(12'h123, 5'd1, 3'b000, 7'b0110111), rand_word(), rand_word(),
                        rand_word(), '0, 1'b1, 1'b0);
        issue_and_check(enc_r(7'h00, 3'b010, `OPC_OP_32), rand_word(), rand_word(),
                        rand_word(), '0, 1'b1, 1'b0);
        issue_and_check(enc_i(12'h000, 5'd0, 3'b000, `OPC_SYSTEM), rand_word(), rand_word(),
                        rand_word(), '0, 1'b1, 1'b0);
    endtask

    task automatic back_to_back();
        logic [31:0] instrs [0:4];
        model_op_e   ops    [0:4];
        xlen_t       a      [0:4];
        xlen_t       b      [0:4];
        instrs = '{enc_r(7'h00, 3'b000, `OPC_OP), enc_r(7'h20, 3'b000, `OPC_OP),
                   enc_r(7'h00, 3'b100, `OPC_OP), enc_r(7'h00, 3'b000, `OPC_OP_32),
                   enc_r(7'h01, 3'b000, `OPC_OP_32)};
        ops    = '{M_ADD, M_SUB, M_XOR, M_ADDW, M_MULW};
        for (int k = 0; k < 5; k++) begin
            a[k] = rand_word();
            b[k] = rand_word();
        end
        for (int k = 0; k <= 5; k++) begin
            @(posedge i_clk);
            if (k < 5) begin
                drive_instr(instrs[k], a[k], b[k], '0);
            end else begin
                i_valid    <= 1'b0;
                i_instr    <= enc_r(7'h00, 3'b010, `OPC_OP_32); // Illegal word while idle.
                i_rs1_data <= ~a[4];
            end
            @(negedge i_clk);
            if (k == 0) begin
                check_value("o_valid before the stream", xlen_t'(o_valid), '0);
            end else begin
                compare_outputs(model_result(ops[k-1], a[k-1], b[k-1]), 1'b0, 1'b1);
            end
        end
        @(negedge i_clk);
        check_value("o_valid after the stream", xlen_t'(o_valid), '0);
        // Idle cycle with new inputs leaves the last result in place.
        check_value("o_result while idle", o_result, model_result(ops[4], a[4], b[4]));
        check_value("o_illegal while idle", xlen_t'(o_illegal), '0);
    endtask

    initial begin
        error_count = 0;
        void'($urandom(32'h1b69));
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_instr     = '0;
        i_rs1_data  = '0;
        i_rs2_data  = '0;
        i_csr_data  = '0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        integer_ops();
        word_ops();
        mem_and_branch();
        csr_ops();
        illegal_instrs();
        back_to_back();
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
+incdir+testbench
logic/core_pkg.sv
logic/instr_decoder.sv
logic/alu_decoder.sv
logic/alu.sv
logic/exec_unit.sv
testbench/tb_exec_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grade the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module tb_exec_unit

# The run may stop with a nonzero status; the log decides the outcome.
./obj_dir/Vtb_exec_unit > sim.log 2>&1 || true
cat sim.log

if grep -qxF "** PASS **" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
